//--- list.f
hw/pad_pkg.sv
hw/pad_if.sv
hw/pad_regs.sv
hw/jtag_overlay_mux.sv
hw/padring.sv
hw/pad_top.sv
test/tb_pad_asserts.sv
test/tb_pad_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pad_top testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -f list.f --top-module tb_pad_top -o tb_pad_top

# Let assertion errors reach the testbench summary
./obj_dir/tb_pad_top +verilator+error+limit+100 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"

//--- test/tb_pad_top.sv
/* Testbench for pad_top with LFSR stimulus, a register and padring model,
   compare tasks, watchdog and summary */
`default_nettype none

module tb_pad_top;
  import pad_pkg::*;

  localparam int      NumTests   = 6;
  localparam int      TestCycles = 400;  // Back-pressure test is the longest
  localparam int      WaitLimit  = 16;
  localparam io_vec_t OvlMask    = io_vec_t'(4'hF) << PadTck;
  localparam io_vec_t JtagIn     = io_vec_t'(3'h7) << PadTck;  // TCK, TMS, TDI

  logic             clk;
  logic             rst_n;
  logic [AddrW-1:0] awaddr, araddr;
  logic             awvalid, wvalid, bready, arvalid, rready, jtag_tdo;
  logic             awready, wready, bvalid, arready, rvalid;
  logic             jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n;
  logic [31:0]      wdata, rdata;
  logic [3:0]       wstrb;
  axi_resp_t        bresp, rresp;
  io_vec_t          pad_in, pad_out, pad_oe;

  io_vec_t     model_reg [4];  // OUT, OE, INV, OD
  logic [15:0] lfsr_state = 16'd53;
  string       cur_test;
  int          test_checks, test_errs, total_checks, total_errs, failed_tests;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  pad_top i_dut (
    .clk_main_i    ( clk         ),
    .rst_n_i       ( rst_n       ),
    .s_awaddr_i    ( awaddr      ),
    .s_awvalid_i   ( awvalid     ),
    .s_awready_o   ( awready     ),
    .s_wdata_i     ( wdata       ),
    .s_wstrb_i     ( wstrb       ),
    .s_wvalid_i    ( wvalid      ),
    .s_wready_o    ( wready      ),
    .s_bresp_o     ( bresp       ),
    .s_bvalid_o    ( bvalid      ),
    .s_bready_i    ( bready      ),
    .s_araddr_i    ( araddr      ),
    .s_arvalid_i   ( arvalid     ),
    .s_arready_o   ( arready     ),
    .s_rdata_o     ( rdata       ),
    .s_rresp_o     ( rresp       ),
    .s_rvalid_o    ( rvalid      ),
    .s_rready_i    ( rready      ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_tdo_i    ( jtag_tdo    )
  );

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic io_vec_t byte_merge(input io_vec_t old_val, input logic [31:0] data,
                                         input logic [3:0] strb);
    logic [31:0] lanes;
    lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return io_vec_t'((32'(old_val) & ~lanes) | (data & lanes));
  endfunction

  // IN as the core should read it
  function automatic logic [31:0] expected_in(input logic active);
    io_vec_t v;
    v = pad_in ^ model_reg[2];
    if (active) begin
      v = (v & ~OvlMask) | (TieOffIn & OvlMask);
    end
    return 32'(v);
  endfunction

  function automatic logic [AddrW-1:0] pick_unmapped();
    logic [AddrW-1:0] a;
    a = AddrW'(rand_bits(AddrW));
    while (a inside {AddrOut, AddrOe, AddrInv, AddrOd, AddrIn, AddrStatus}) begin
      a = AddrW'(rand_bits(AddrW));
    end
    return a;
  endfunction

  //////////////////////////////
  // Checks and reporting
  //////////////////////////////

  task automatic check_vec(input string what, input io_vec_t exp, input io_vec_t act);
    test_checks++;
    if (act !== exp) begin
      test_errs++;
      $display("FAIL %s: %s expected 0x%05h actual 0x%05h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    test_checks++;
    if (act !== exp) begin
      test_errs++;
      $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
    test_checks++;
    if (act !== exp) begin
      test_errs++;
      $display("FAIL %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
    end
  endtask

  task automatic stuck(input string sig);
    test_errs++;
    $display("Handshake error in %s: %s did not rise within %0d cycles",
             cur_test, sig, WaitLimit);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic finish_test();
    $display("test %-16s %0d checks, %0d errors", cur_test, test_checks, test_errs);
    total_checks += test_checks;
    total_errs   += test_errs;
    if (test_errs != 0) failed_tests++;
  endtask

  //////////////////////////////
  // Bus and pad tasks
  //////////////////////////////

  task automatic write_reg(input logic [AddrW-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int stall, output axi_resp_t resp);
    int   n;
    logic ok;
    n    = 0;
    resp = 'x;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready) && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    ok = awready & wready;
    @(posedge clk);  // Accepting edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!ok) begin
      stuck("awready and wready");
      return;
    end
    n = 0;
    @(negedge clk);
    while (!bvalid && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) begin
      stuck("bvalid");
      return;
    end
    repeat (stall) @(negedge clk);  // bready held low
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [AddrW-1:0] addr, input int stall,
                          output logic [31:0] data, output axi_resp_t resp);
    int   n;
    logic ok;
    n    = 0;
    data = 'x;
    resp = 'x;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    ok = arready;
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    if (!ok) begin
      stuck("arready");
      return;
    end
    n = 0;
    @(negedge clk);
    while (!rvalid && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      stuck("rvalid");
      return;
    end
    repeat (stall) @(negedge clk);
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // Padring rule on the model registers, with the overlay when active
  task automatic pads_match(input logic active);
    io_vec_t o, e, iv, d, drv;
    o  = model_reg[0];
    e  = model_reg[1];
    iv = model_reg[2];
    d  = model_reg[3];
    if (active) begin
      e         = e & ~JtagIn;
      o[PadTdo] = jtag_tdo;
      e[PadTdo] = 1'b1;
      iv        = iv & ~OvlMask;
      d         = d & ~OvlMask;
    end
    drv = o ^ iv;
    @(negedge clk);
    check_vec("pad_out_o", drv & ~d, pad_out);
    check_vec("pad_oe_o", e & ~(d & drv), pad_oe);
  endtask

  task automatic jtag_pins(input logic active);
    io_vec_t seen;
    io_vec_t exp;
    seen = '0;
    exp  = '0;
    @(negedge clk);
    seen[PadJtagEn] = jtag_trst_n;
    seen[PadTck]    = jtag_tck;
    seen[PadTms]    = jtag_tms;
    seen[PadTdi]    = jtag_tdi;
    if (active) begin
      exp = (pad_in & JtagIn) | (io_vec_t'(1) << PadJtagEn);
    end
    check_vec("JTAG pins", exp, seen);
  endtask

  task automatic hold_pads(input io_vec_t v, input logic tdo);
    @(posedge clk);
    #1;
    pad_in   = v;
    jtag_tdo = tdo;
    repeat (3) @(posedge clk);
  endtask

  task automatic random_access(input int wr_stall, input int rd_stall);
    logic [31:0]      data;
    logic [31:0]      rd;
    logic [3:0]       strb;
    logic [AddrW-1:0] addr;
    int               sel;
    axi_resp_t        resp;
    sel  = int'(rand_bits(2));
    addr = AddrW'(sel * 4);
    data = rand_bits(32);
    strb = 4'(rand_bits(4));
    if (sel == 2) data[PadJtagEn] = 1'b0;  // Strap never inverted
    write_reg(addr, data, strb, wr_stall, resp);
    check_resp("write response", RespOkay, resp);
    model_reg[sel] = byte_merge(model_reg[sel], data, strb);
    pads_match(1'b0);
    read_reg(addr, rd_stall, rd, resp);
    check_resp("read response", RespOkay, resp);
    check_word("read-back", 32'(model_reg[sel]), rd);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    io_vec_t          v;
    logic [31:0]      rd;
    logic [31:0]      tmp;
    logic [AddrW-1:0] addr;
    axi_resp_t        resp;
    rst_n    = 1'b0;
    awaddr   = '0;
    araddr   = '0;
    wdata    = '0;
    wstrb    = '0;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    pad_in   = '0;
    jtag_tdo = 1'b0;
    for (int i = 0; i < 4; i++) model_reg[i] = '0;
    total_checks = 0;
    total_errs   = 0;
    failed_tests = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_values");
    jtag_pins(1'b0);
    check_vec("pad_oe_o", io_vec_t'(0), pad_oe);
    for (int i = 0; i < 6; i++) begin
      read_reg(AddrW'(4 * i), 0, rd, resp);
      check_resp("read response", RespOkay, resp);
      check_word("register", 32'd0, rd);
    end
    finish_test();

    start_test("write_readback");
    for (int i = 0; i < 24; i++) random_access(0, 0);
    finish_test();

    start_test("input_sync");
    for (int i = 0; i < 12; i++) begin
      v = io_vec_t'(rand_bits(NumIos));
      v[PadJtagEn] = 1'b0;
      hold_pads(v, 1'b0);
      read_reg(AddrIn, 0, rd, resp);
      check_word("IN", expected_in(1'b0), rd);
    end
    finish_test();

    start_test("jtag_overlay");
    for (int i = 0; i < 8; i++) begin
      v   = io_vec_t'(rand_bits(NumIos)) | (io_vec_t'(1) << PadJtagEn);
      tmp = rand_bits(1);
      hold_pads(v, tmp[0]);
      read_reg(AddrStatus, 0, rd, resp);
      check_word("STATUS", 32'd1, rd);
      jtag_pins(1'b1);
      pads_match(1'b1);
      read_reg(AddrIn, 0, rd, resp);
      check_word("IN", expected_in(1'b1), rd);
    end
    v[PadJtagEn] = 1'b0;  // Release the strap
    hold_pads(v, 1'b0);
    jtag_pins(1'b0);
    pads_match(1'b0);
    read_reg(AddrStatus, 0, rd, resp);
    check_word("STATUS", 32'd0, rd);
    for (int i = 0; i < 4; i++) random_access(0, 0);
    finish_test();

    start_test("illegal_access");
    write_reg(AddrIn, rand_bits(32), 4'hF, 0, resp);
    check_resp("write IN", RespSlvErr, resp);
    write_reg(AddrStatus, rand_bits(32), 4'hF, 0, resp);
    check_resp("write STATUS", RespSlvErr, resp);
    for (int i = 0; i < 6; i++) begin
      addr = pick_unmapped();
      write_reg(addr, rand_bits(32), 4'hF, 0, resp);
      check_resp("unmapped write", RespSlvErr, resp);
      addr = pick_unmapped();
      read_reg(addr, 0, rd, resp);
      check_resp("unmapped read", RespSlvErr, resp);
      check_word("unmapped data", 32'd0, rd);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(AddrW'(4 * i), 0, rd, resp);
      check_word("unchanged register", 32'(model_reg[i]), rd);
    end
    finish_test();

    start_test("back_pressure");
    for (int i = 0; i < 10; i++) begin
      random_access(int'(rand_bits(3)), int'(rand_bits(3)));
      random_access(0, 0);
    end
    finish_test();

    if (i_dut.i_asserts.fail_cnt != 0) begin
      $display("Bound assertions failed %0d times", i_dut.i_asserts.fail_cnt);
      total_errs += i_dut.i_asserts.fail_cnt;
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             NumTests, failed_tests, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NumTests * TestCycles * 2) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", NumTests * TestCycles * 2);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_pad_top

`default_nettype wire

//--- test/tb_pad_asserts.sv
/* Bound assertions on the AXI4-Lite response channels,
   the reset state and the JTAG overlay enables */
`default_nettype none

module tb_pad_asserts (
  input logic               clk_main_i,
  input logic               rst_n_i,
  input logic               bvalid_i,
  input logic               bready_i,
  input pad_pkg::axi_resp_t bresp_i,
  input logic               rvalid_i,
  input logic               rready_i,
  input logic [31:0]        rdata_i,
  input pad_pkg::axi_resp_t rresp_i,
  input pad_pkg::io_vec_t   pad_oe_i,
  input logic               trst_n_i
);
  import pad_pkg::*;

  int fail_cnt = 0;  // Summed by the testbench at the end

  bresp_hold: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("Write response dropped or changed before bready");
      fail_cnt++;
    end

  rdata_hold: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("Read response dropped or changed before rready");
      fail_cnt++;
    end

  // First edge out of reset
  reset_idle: assert property (@(posedge clk_main_i)
    $rose(rst_n_i) |-> !bvalid_i && !rvalid_i && !trst_n_i)
    else begin
      $error("Valid outputs or TAP reset not idle after reset");
      fail_cnt++;
    end

  // Probe drives TCK, TMS and TDI
  jtag_inputs: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    trst_n_i |-> pad_oe_i[PadTdi:PadTck] == 3'b000)
    else begin
      $error("Pad enable set on a JTAG input pad");
      fail_cnt++;
    end

endmodule : tb_pad_asserts

bind pad_top tb_pad_asserts i_asserts (
  .clk_main_i ( clk_main_i    ),
  .rst_n_i    ( rst_n_i       ),
  .bvalid_i   ( s_bvalid_o    ),
  .bready_i   ( s_bready_i    ),
  .bresp_i    ( s_bresp_o     ),
  .rvalid_i   ( s_rvalid_o    ),
  .rready_i   ( s_rready_i    ),
  .rdata_i    ( s_rdata_o     ),
  .rresp_i    ( s_rresp_o     ),
  .pad_oe_i   ( pad_oe_o      ),
  .trst_n_i   ( jtag_trst_n_o )
);

`default_nettype wire

//--- hw/pad_top.sv
/* Top level with the register block, JTAG overlay mux and padring */
`default_nettype none

module pad_top (
  input  logic                      clk_main_i,
  input  logic                      rst_n_i,
  // AXI4-Lite slave
  input  logic [pad_pkg::AddrW-1:0] s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  logic [31:0]               s_wdata_i,
  input  logic [3:0]                s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  output pad_pkg::axi_resp_t        s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  input  logic [pad_pkg::AddrW-1:0] s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  output logic [31:0]               s_rdata_o,
  output pad_pkg::axi_resp_t        s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  // Pads, split in place of inout
  input  pad_pkg::io_vec_t          pad_in_i,
  output pad_pkg::io_vec_t          pad_out_o,
  output pad_pkg::io_vec_t          pad_oe_o,
  // JTAG
  output logic                      jtag_tck_o,
  output logic                      jtag_tms_o,
  output logic                      jtag_tdi_o,
  output logic                      jtag_trst_n_o,
  input  logic                      jtag_tdo_i
);

  logic jtag_active;

  pad_core_if core_if ();
  pad_ring_if ring_if ();

  //////////////////////////////
  // Padring
  //////////////////////////////

  padring padring (
    .ring      ( ring_if.ring ),
    .pad_in_i  ( pad_in_i     ),
    .pad_out_o ( pad_out_o    ),
    .pad_oe_o  ( pad_oe_o     )
  );

  //////////////////////////////
  // JTAG overlay mux
  //////////////////////////////

  jtag_overlay_mux jtag_overlay_mux (
    .clk_main_i    ( clk_main_i    ),
    .rst_n_i       ( rst_n_i       ),
    .core          ( core_if.mux   ),
    .ring          ( ring_if.mux   ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_active_o ( jtag_active   )
  );

  //////////////////////////////
  // Register block, core side
  //////////////////////////////

  pad_regs pad_regs (
    .clk_main_i    ( clk_main_i    ),
    .rst_n_i       ( rst_n_i       ),
    .s_awaddr_i    ( s_awaddr_i    ),
    .s_awvalid_i   ( s_awvalid_i   ),
    .s_awready_o   ( s_awready_o   ),
    .s_wdata_i     ( s_wdata_i     ),
    .s_wstrb_i     ( s_wstrb_i     ),
    .s_wvalid_i    ( s_wvalid_i    ),
    .s_wready_o    ( s_wready_o    ),
    .s_bresp_o     ( s_bresp_o     ),
    .s_bvalid_o    ( s_bvalid_o    ),
    .s_bready_i    ( s_bready_i    ),
    .s_araddr_i    ( s_araddr_i    ),
    .s_arvalid_i   ( s_arvalid_i   ),
    .s_arready_o   ( s_arready_o   ),
    .s_rdata_o     ( s_rdata_o     ),
    .s_rresp_o     ( s_rresp_o     ),
    .s_rvalid_o    ( s_rvalid_o    ),
    .s_rready_i    ( s_rready_i    ),
    .jtag_active_i ( jtag_active   ),  // STATUS bit 0
    .core          ( core_if.core  )
  );

endmodule : pad_top

`default_nettype wire

//--- hw/padring.sv
/* Padring model with per-pad inversion and open-drain attributes */
`default_nettype none

module padring (
  pad_ring_if.ring         ring,
  input  pad_pkg::io_vec_t pad_in_i,
  output pad_pkg::io_vec_t pad_out_o,
  output pad_pkg::io_vec_t pad_oe_o
);
  import pad_pkg::*;

  io_vec_t drv;  // Value the pad would drive

  //////////////////////////////
  // Output path
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NumIos; i++) begin
      drv[i] = ring.out[i] ^ ring.inv[i];
      if (ring.od[i]) begin
        // Open drain pulls low only, floats for a one
        pad_out_o[i] = 1'b0;
        pad_oe_o[i]  = ring.oe[i] & ~drv[i];
      end else begin
        pad_out_o[i] = drv[i];
        pad_oe_o[i]  = ring.oe[i];
      end
    end
  end

  //////////////////////////////
  // Input path
  //////////////////////////////

  // Same inversion on the way in
  assign ring.in = pad_in_i ^ ring.inv;

endmodule : padring

`default_nettype wire

//--- hw/jtag_overlay_mux.sv
/* Strap synchronizer and JTAG takeover of the four overlay pads */
`default_nettype none

module jtag_overlay_mux (
  input  logic     clk_main_i,
  input  logic     rst_n_i,
  pad_core_if.mux  core,
  pad_ring_if.mux  ring,
  // JTAG side
  output logic     jtag_tck_o,
  output logic     jtag_tms_o,
  output logic     jtag_tdi_o,
  output logic     jtag_trst_n_o,
  input  logic     jtag_tdo_i,
  output logic     jtag_active_o
);
  import pad_pkg::*;

  logic    strap_meta_q;
  logic    strap_sync_q;
  io_vec_t ovl_mask;

  // Strap pad, as the core sees it
  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_meta_q <= 1'b0;
      strap_sync_q <= 1'b0;
    end else begin
      strap_meta_q <= ring.in[PadJtagEn];
      strap_sync_q <= strap_meta_q;
    end
  end

  assign jtag_active_o = strap_sync_q;
  assign jtag_trst_n_o = strap_sync_q;  // TAP held in reset when overlay is off

  assign ovl_mask = (io_vec_t'(1) << PadTck) | (io_vec_t'(1) << PadTms) |
                    (io_vec_t'(1) << PadTdi) | (io_vec_t'(1) << PadTdo);

  //////////////////////////////
  // Overlay
  //////////////////////////////

  always_comb begin
    ring.out = core.out;
    ring.oe  = core.oe;
    ring.inv = core.inv;
    ring.od  = core.od;
    if (strap_sync_q) begin
      // Inputs from the probe
      ring.oe[PadTck] = 1'b0;
      ring.oe[PadTms] = 1'b0;
      ring.oe[PadTdi] = 1'b0;
      // TDO driven straight, no attributes
      ring.out[PadTdo] = jtag_tdo_i;
      ring.oe[PadTdo]  = 1'b1;
      ring.inv = core.inv & ~ovl_mask;
      ring.od  = core.od & ~ovl_mask;
    end
  end

  // Core reads the tie-off on the overlay pads while JTAG owns them
  assign core.in = strap_sync_q ? ((ring.in & ~ovl_mask) | (TieOffIn & ovl_mask)) : ring.in;

  assign jtag_tck_o = strap_sync_q & ring.in[PadTck];
  assign jtag_tms_o = strap_sync_q & ring.in[PadTms];
  assign jtag_tdi_o = strap_sync_q & ring.in[PadTdi];

endmodule : jtag_overlay_mux

`default_nettype wire

//--- hw/pad_regs.sv
/* AXI4-Lite slave with the OUT, OE, INV and OD pad registers,
   the synchronized IN register and the STATUS word */
`default_nettype none

module pad_regs (
  input  logic                      clk_main_i,
  input  logic                      rst_n_i,
  // Write address channel
  input  logic [pad_pkg::AddrW-1:0] s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  // Write data channel
  input  logic [31:0]               s_wdata_i,
  input  logic [3:0]                s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  // Write response channel
  output pad_pkg::axi_resp_t        s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  // Read address channel
  input  logic [pad_pkg::AddrW-1:0] s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  // Read data channel
  output logic [31:0]               s_rdata_o,
  output pad_pkg::axi_resp_t        s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  // Status and pads
  input  logic                      jtag_active_i,
  pad_core_if.core                  core
);
  import pad_pkg::*;

  io_vec_t     out_q;
  io_vec_t     oe_q;
  io_vec_t     inv_q;
  io_vec_t     od_q;
  io_vec_t     in_meta_q;
  io_vec_t     in_sync_q;
  logic        wr_fire;
  logic        rd_fire;
  axi_resp_t   wr_resp;
  axi_resp_t   rd_resp;
  logic [31:0] rd_word;
  logic        bvalid_q;
  logic        rvalid_q;
  axi_resp_t   bresp_q;
  axi_resp_t   rresp_q;
  logic [31:0] rdata_q;

  // Address decode and access rights for both channels
  function automatic axi_resp_t check_addr(logic [AddrW-1:0] addr, logic is_wr);
    axi_resp_t resp;
    case (addr)
      AddrOut, AddrOe, AddrInv, AddrOd: resp = RespOkay;
      AddrIn, AddrStatus:               resp = is_wr ? RespSlvErr : RespOkay;
      default:                          resp = RespSlvErr;
    endcase
    return resp;
  endfunction

  // Byte lanes from wstrb over the old register value
  function automatic io_vec_t merge(io_vec_t old_val, logic [31:0] data, logic [3:0] strb);
    logic [31:0] word;
    word = 32'(old_val);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    return word[NumIos-1:0];
  endfunction

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // One acceptance per response, stalled while a response waits
  assign wr_fire     = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign rd_fire     = s_arvalid_i & ~rvalid_q;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign s_arready_o = rd_fire;

  assign wr_resp = check_addr(s_awaddr_i, 1'b1);
  assign rd_resp = check_addr(s_araddr_i, 1'b0);

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (s_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload, held by the stall above
  always_ff @(posedge clk_main_i) begin
    if (wr_fire) begin
      bresp_q <= wr_resp;
    end
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
      inv_q <= '0;
      od_q  <= '0;
    end else if (wr_fire && wr_resp == RespOkay) begin
      case (s_awaddr_i)
        AddrOut: out_q <= merge(out_q, s_wdata_i, s_wstrb_i);
        AddrOe:  oe_q  <= merge(oe_q,  s_wdata_i, s_wstrb_i);
        AddrInv: inv_q <= merge(inv_q, s_wdata_i, s_wstrb_i);
        AddrOd:  od_q  <= merge(od_q,  s_wdata_i, s_wstrb_i);
        default: ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= core.in;
      in_sync_q <= in_meta_q;
    end
  end

  always_comb begin
    case (s_araddr_i)
      AddrOut:    rd_word = 32'(out_q);
      AddrOe:     rd_word = 32'(oe_q);
      AddrInv:    rd_word = 32'(inv_q);
      AddrOd:     rd_word = 32'(od_q);
      AddrIn:     rd_word = 32'(in_sync_q);
      AddrStatus: rd_word = 32'(jtag_active_i);
      default:    rd_word = '0;  // Unmapped reads as zero
    endcase
  end

  assign core.out = out_q;
  assign core.oe  = oe_q;
  assign core.inv = inv_q;
  assign core.od  = od_q;

endmodule : pad_regs

`default_nettype wire

//--- hw/pad_if.sv
/* Core-side and padring-side pad bundles with their modports */
`default_nettype none

// Between the register block and the JTAG overlay mux
interface pad_core_if;
  import pad_pkg::*;

  io_vec_t out;
  io_vec_t oe;
  io_vec_t inv;
  io_vec_t od;
  io_vec_t in;   // Core-side input after inversion

  modport core (output out, oe, inv, od, input in);
  modport mux  (input out, oe, inv, od, output in);

endinterface : pad_core_if

// Between the JTAG overlay mux and the padring
interface pad_ring_if;
  import pad_pkg::*;

  io_vec_t out;
  io_vec_t oe;
  io_vec_t inv;
  io_vec_t od;
  io_vec_t in;

  modport mux  (output out, oe, inv, od, input in);
  modport ring (input out, oe, inv, od, output in);

endinterface : pad_ring_if

`default_nettype wire

//--- hw/pad_pkg.sv
/* Pad counts and pad indices, register byte offsets,
   JTAG tie-off values and AXI4-Lite response codes */
`default_nettype none

package pad_pkg;

  //////////////////////////////
  // Pads
  //////////////////////////////

  localparam int NumIos = 20;

  // Overlay pads at the top of the vector
  localparam int PadJtagEn = 15;  // Strap, high selects JTAG
  localparam int PadTck    = 16;
  localparam int PadTms    = 17;
  localparam int PadTdi    = 18;
  localparam int PadTdo    = 19;

  localparam int NumGpio = PadJtagEn;  // Plain GPIOs below the strap

  typedef logic [NumIos-1:0] io_vec_t;

  // Core view of the overlay pads while JTAG owns them
  // TMS pad doubles as an active low chip select, so it idles high
  localparam io_vec_t TieOffIn = io_vec_t'(1) << PadTms;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam int AddrW = 8;

  localparam logic [AddrW-1:0] AddrOut    = 8'h00;
  localparam logic [AddrW-1:0] AddrOe     = 8'h04;
  localparam logic [AddrW-1:0] AddrInv    = 8'h08;
  localparam logic [AddrW-1:0] AddrOd     = 8'h0C;
  localparam logic [AddrW-1:0] AddrIn     = 8'h10;  // Read only
  localparam logic [AddrW-1:0] AddrStatus = 8'h14;  // Read only

  // AXI response codes
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RespOkay   = 2'd0;
  localparam axi_resp_t RespSlvErr = 2'd2;

endpackage : pad_pkg

`default_nettype wire
